/* input_pkg.sv */
package input_pkg;

    // data path sizes
    localparam int isa_width  = 32;                      // cpu data word
    localparam int switch_cnt = 16;                      // toggle switches on the board
    localparam int max_digits = 8;                       // decimal digits taken per entry
    localparam int count_w    = $clog2(max_digits + 1);  // digit counter width

    // key code is {row_n, col_n}, both one-cold
    typedef logic [7:0] key_code_t;

    localparam key_code_t key_0         = 8'b0111_1101;
    localparam key_code_t key_1         = 8'b1110_1110;
    localparam key_code_t key_2         = 8'b1110_1101;
    localparam key_code_t key_3         = 8'b1110_1011;
    localparam key_code_t key_4         = 8'b1101_1110;
    localparam key_code_t key_5         = 8'b1101_1101;
    localparam key_code_t key_6         = 8'b1101_1011;
    localparam key_code_t key_7         = 8'b1011_1110;
    localparam key_code_t key_8         = 8'b1011_1101;
    localparam key_code_t key_9         = 8'b1011_1011;
    localparam key_code_t key_backspace = 8'b0111_1110;  // "*"
    localparam key_code_t key_enter     = 8'b0111_1011;  // "#"
    localparam key_code_t key_pause     = 8'b1110_0111;  // "A"
    localparam key_code_t key_toggle    = 8'b1101_0111;  // "B"
    localparam key_code_t key_c         = 8'b1011_0111;  // not used
    localparam key_code_t key_d         = 8'b0111_0111;  // not used
    localparam key_code_t key_none      = 8'b1111_1111;  // idle, no key

    typedef enum logic [1:0] {
        st_block  = 2'b00,  // waiting for a request
        st_switch = 2'b01,  // switches are the source
        st_keypad = 2'b10,  // gathering keypad digits
        st_halt   = 2'b11   // cpu paused
    } input_state_t;

    // keypad scan timing
    localparam int scan_dwell = 8;                    // cycles per column
    localparam int scan_cnt_w = $clog2(scan_dwell);

    // display multiplex timing
    localparam int digit_dwell = 16;                  // cycles per lit digit
    localparam int digit_cnt_w = $clog2(digit_dwell);
    localparam int disp_digits = isa_width / 4;       // one hex digit per nibble
    localparam int disp_idx_w  = $clog2(disp_digits);

endpackage

/* keypad_scanner.sv */
`timescale 1ns/1ps

module keypad_scanner (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [3:0]           row_sense,  // active low, pulled high when idle
    output logic [3:0]           col_drive,  // one column low at a time
    output input_pkg::key_code_t key_coord   // one cycle per accepted press
);

    typedef logic [input_pkg::scan_cnt_w-1:0] dwell_t;

    dwell_t               dwell_cnt;
    logic [1:0]           col_idx;
    logic [3:0]           row_meta;   // pins are asynchronous
    logic [3:0]           row_sync;
    logic                 sample;     // last cycle of a column dwell
    logic                 scan_end;   // last sample of column 3
    logic                 row_hit;
    logic                 seen_any;   // some key seen in this scan
    input_pkg::key_code_t scan_code;  // first key seen in this scan
    input_pkg::key_code_t prev_code;  // capture of the previous scan
    input_pkg::key_code_t code_next;
    logic                 seen_next;
    logic                 armed;      // cleared after a pulse until keys are released

    assign col_drive = ~(4'b0001 << col_idx);
    assign sample    = (dwell_cnt == dwell_t'(input_pkg::scan_dwell - 1));
    assign scan_end  = sample && (col_idx == 2'd3);
    assign row_hit   = sample && (row_sync != 4'b1111);

    // columns go 0 to 3, so keeping the first hit lets the lowest column win
    always_comb begin
        code_next = scan_code;
        seen_next = seen_any;
        if (row_hit && !seen_any) begin
            code_next = {row_sync, col_drive};
            seen_next = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_meta <= 4'b1111;
            row_sync <= 4'b1111;
        end else begin
            row_meta <= row_sense;
            row_sync <= row_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            col_idx   <= 2'd0;
        end else if (sample) begin
            dwell_cnt <= '0;
            col_idx   <= col_idx + 2'd1;  // wraps after column 3
        end else begin
            dwell_cnt <= dwell_cnt + dwell_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_any  <= 1'b0;
            scan_code <= input_pkg::key_none;
            prev_code <= input_pkg::key_none;
            armed     <= 1'b1;
            key_coord <= input_pkg::key_none;
        end else begin
            key_coord <= input_pkg::key_none;  // idle unless a press is accepted
            if (scan_end) begin
                seen_any  <= 1'b0;
                scan_code <= input_pkg::key_none;
                if (seen_next) begin
                    // two scans in a row with the same key
                    if (armed && (code_next == prev_code)) begin
                        key_coord <= code_next;
                        armed     <= 1'b0;
                    end
                    prev_code <= code_next;
                end else begin
                    prev_code <= input_pkg::key_none;
                    armed     <= 1'b1;  // clean scan, ready for the next press
                end
            end else begin
                seen_any  <= seen_next;
                scan_code <= code_next;
            end
        end
    end

endmodule

/* input_unit.sv */
`timescale 1ns/1ps

module input_unit (
    input  logic                                clk,
    input  logic                                rst_n,
    input  input_pkg::key_code_t                key_coord,       // from keypad scanner
    input  logic [input_pkg::switch_cnt-1:0]    switch_map,      // toggle switches
    input  logic                                uart_complete,   // program upload done
    input  logic                                input_enable,    // memory wants a value
    output logic                                input_complete,  // entry finished
    output logic [input_pkg::isa_width-1:0]     input_data,
    output logic                                switch_enable,   // switches are the source
    output logic                                cpu_pause,
    output input_pkg::input_state_t             input_state
);

    typedef logic [input_pkg::isa_width-1:0] word_t;
    typedef logic [input_pkg::count_w-1:0]   count_t;

    word_t      keypad_data;
    count_t     digit_cnt;    // real digits taken so far
    logic       is_digit;
    logic [3:0] digit_val;
    word_t      appended;
    logic       can_append;

    assign input_data = switch_enable ? word_t'(switch_map) : keypad_data;

    // key code to decimal digit, C and D fall out as non-digits
    always_comb begin
        is_digit  = 1'b1;
        digit_val = 4'd0;
        case (key_coord)
            input_pkg::key_0: digit_val = 4'd0;
            input_pkg::key_1: digit_val = 4'd1;
            input_pkg::key_2: digit_val = 4'd2;
            input_pkg::key_3: digit_val = 4'd3;
            input_pkg::key_4: digit_val = 4'd4;
            input_pkg::key_5: digit_val = 4'd5;
            input_pkg::key_6: digit_val = 4'd6;
            input_pkg::key_7: digit_val = 4'd7;
            input_pkg::key_8: digit_val = 4'd8;
            input_pkg::key_9: digit_val = 4'd9;
            default:          is_digit  = 1'b0;
        endcase
    end

    assign appended   = keypad_data * word_t'(10) + word_t'(digit_val);  // wraps at word size
    assign can_append = digit_cnt < count_t'(input_pkg::max_digits);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            input_complete <= 1'b0;
            switch_enable  <= 1'b0;
            cpu_pause      <= 1'b0;
            input_state    <= input_pkg::st_block;
            keypad_data    <= '0;
            digit_cnt      <= '0;
        end else begin
            case (input_state)
                input_pkg::st_switch: begin
                    case (key_coord)
                        input_pkg::key_toggle: begin
                            input_state   <= input_pkg::st_keypad;
                            switch_enable <= 1'b0;
                        end
                        input_pkg::key_enter: begin
                            input_state    <= input_pkg::st_block;
                            input_complete <= 1'b1;
                            digit_cnt      <= '0;
                        end
                        input_pkg::key_pause: begin
                            input_state    <= input_pkg::st_halt;
                            input_complete <= 1'b1;
                            digit_cnt      <= '0;
                            cpu_pause      <= 1'b1;
                        end
                        default: ;  // other keys have no meaning here
                    endcase
                end

                input_pkg::st_keypad: begin
                    if (!input_enable) begin
                        input_state <= input_pkg::st_block;  // request withdrawn
                    end else begin
                        case (key_coord)
                            input_pkg::key_toggle: begin
                                input_state   <= input_pkg::st_switch;
                                switch_enable <= 1'b1;
                            end
                            input_pkg::key_backspace: begin
                                if (digit_cnt != '0) begin
                                    keypad_data <= keypad_data / word_t'(10);
                                    digit_cnt   <= digit_cnt - count_t'(1);
                                end
                            end
                            input_pkg::key_enter: begin
                                input_state    <= input_pkg::st_block;
                                input_complete <= 1'b1;
                                digit_cnt      <= '0;
                            end
                            input_pkg::key_pause: begin
                                input_state    <= input_pkg::st_halt;
                                input_complete <= 1'b1;
                                digit_cnt      <= '0;
                                cpu_pause      <= 1'b1;
                            end
                            default: begin
                                if (is_digit && can_append) begin
                                    keypad_data <= appended;
                                    digit_cnt   <= digit_cnt + count_t'(1);
                                end
                            end
                        endcase
                    end
                end

                input_pkg::st_halt: begin
                    // resume only once a new program is in
                    if (uart_complete && (key_coord == input_pkg::key_pause)) begin
                        input_state <= input_pkg::st_block;
                        cpu_pause   <= 1'b0;
                    end
                end

                default: begin  // st_block
                    if (key_coord == input_pkg::key_pause) begin
                        input_state <= input_pkg::st_halt;
                        cpu_pause   <= 1'b1;
                    end else if (input_enable) begin
                        input_state    <= input_pkg::st_keypad;
                        input_complete <= 1'b0;
                        keypad_data    <= '0;
                        digit_cnt      <= '0;
                    end
                end
            endcase
        end
    end

endmodule

/* hex_display.sv */
`timescale 1ns/1ps

module hex_display (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [input_pkg::isa_width-1:0] value,
    input  logic                            switch_enable,
    output logic [6:0]                      seg,        // active low, bit 0 is a
    output logic                            dp,         // active low
    output logic [7:0]                      digit_sel   // active low
);

    typedef logic [input_pkg::digit_cnt_w-1:0] dwell_t;
    typedef logic [input_pkg::disp_idx_w-1:0]  idx_t;
    typedef logic [input_pkg::disp_digits-1:0] sel_t;

    dwell_t     dwell_cnt;
    idx_t       digit_idx;
    logic [3:0] nibble;

    // active-high gfedcba pattern, inverted for the common-anode board
    function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
        logic [6:0] on;
        case (hex)
            4'h0: on = 7'h3F;
            4'h1: on = 7'h06;
            4'h2: on = 7'h5B;
            4'h3: on = 7'h4F;
            4'h4: on = 7'h66;
            4'h5: on = 7'h6D;
            4'h6: on = 7'h7D;
            4'h7: on = 7'h07;
            4'h8: on = 7'h7F;
            4'h9: on = 7'h6F;
            4'hA: on = 7'h77;
            4'hB: on = 7'h7C;
            4'hC: on = 7'h39;
            4'hD: on = 7'h5E;
            4'hE: on = 7'h79;
            default: on = 7'h71;  // F
        endcase
        return ~on;
    endfunction

    assign nibble = value[{digit_idx, 2'b00} +: 4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            digit_idx <= '0;
        end else if (dwell_cnt == dwell_t'(input_pkg::digit_dwell - 1)) begin
            dwell_cnt <= '0;
            digit_idx <= digit_idx + idx_t'(1);  // least significant digit first
        end else begin
            dwell_cnt <= dwell_cnt + dwell_t'(1);
        end
    end

    // select, segments and point stay aligned since all three are registered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg       <= 7'h7F;
            dp        <= 1'b1;
            digit_sel <= ~sel_t'(1);
        end else begin
            seg       <= hex_to_seg(nibble);
            dp        <= ~(switch_enable && (digit_idx == idx_t'(input_pkg::disp_digits - 1)));
            digit_sel <= ~(sel_t'(1) << digit_idx);
        end
    end

endmodule

/* input_subsystem.sv */
`timescale 1ns/1ps

module input_subsystem (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [3:0]                       row_sense,      // keypad rows
    input  logic [input_pkg::switch_cnt-1:0] switch_map,
    input  logic                             uart_complete,
    input  logic                             input_enable,
    output logic [3:0]                       col_drive,      // keypad columns
    output logic                             input_complete, // to hazard logic
    output logic [input_pkg::isa_width-1:0]  input_data,
    output logic                             switch_enable,
    output logic                             cpu_pause,      // to hazard logic
    output input_pkg::input_state_t          input_state,
    output logic [6:0]                       seg,
    output logic                             dp,
    output logic [7:0]                       digit_sel
);

    input_pkg::key_code_t key_coord;

    keypad_scanner u_scanner (
        .clk       (clk),
        .rst_n     (rst_n),
        .row_sense (row_sense),
        .col_drive (col_drive),
        .key_coord (key_coord)
    );

    input_unit u_input (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_coord      (key_coord),
        .switch_map     (switch_map),
        .uart_complete  (uart_complete),
        .input_enable   (input_enable),
        .input_complete (input_complete),
        .input_data     (input_data),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .input_state    (input_state)
    );

    // shows whatever the memory would read
    hex_display u_display (
        .clk           (clk),
        .rst_n         (rst_n),
        .value         (input_data),
        .switch_enable (switch_enable),
        .seg           (seg),
        .dp            (dp),
        .digit_sel     (digit_sel)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam real period_ns    = 40.0;
    localparam int  reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;  // released on a rising edge
    end

endmodule

/* tb_input_subsystem.sv */
`timescale 1ns/1ps

module tb_input_subsystem;

    typedef logic [input_pkg::isa_width-1:0] word_t;

    localparam int          hold_cycles  = 100;               // beyond worst scanner latency
    localparam int          max_presses  = 120;
    localparam int unsigned cycle_limit  = (max_presses * 2 * hold_cycles * 5) / 2;

    // key codes of digits 0 to 9
    localparam input_pkg::key_code_t digit_keys [10] = '{
        input_pkg::key_0, input_pkg::key_1, input_pkg::key_2, input_pkg::key_3,
        input_pkg::key_4, input_pkg::key_5, input_pkg::key_6, input_pkg::key_7,
        input_pkg::key_8, input_pkg::key_9};

    // active-low a to g patterns for hex 0 to F
    localparam logic [6:0] seg_table [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

    logic                             clk;
    logic                             rst_n;
    logic [3:0]                       row_sense;
    logic [input_pkg::switch_cnt-1:0] switch_map;
    logic                             uart_complete;
    logic                             input_enable;
    logic [3:0]                       col_drive;
    logic                             input_complete;
    word_t                            input_data;
    logic                             switch_enable;
    logic                             cpu_pause;
    input_pkg::input_state_t          input_state;
    logic [6:0]                       seg;
    logic                             dp;
    logic [7:0]                       digit_sel;

    input_pkg::key_code_t held_key;       // key the keypad model holds down
    input_pkg::key_code_t entry[$];       // keys of the current entry
    int unsigned          cycle_cnt = 0;

    tb_clock_gen u_clock (.clk(clk), .rst_n(rst_n));

    input_subsystem DUT (
        .clk(clk), .rst_n(rst_n), .row_sense(row_sense), .switch_map(switch_map),
        .uart_complete(uart_complete), .input_enable(input_enable), .col_drive(col_drive),
        .input_complete(input_complete), .input_data(input_data),
        .switch_enable(switch_enable), .cpu_pause(cpu_pause), .input_state(input_state),
        .seg(seg), .dp(dp), .digit_sel(digit_sel)
    );

    // a held key pulls its row low while its column is driven
    assign row_sense = ((~col_drive & ~held_key[3:0]) != 4'b0000) ? held_key[7:4] : 4'b1111;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic word_t ref_keypad_value(input input_pkg::key_code_t keys[$]);
        word_t value;
        int    count;
        int    d;
        value = '0;
        count = 0;
        foreach (keys[i]) begin
            d = -1;
            for (int k = 0; k < 10; k++) begin
                if (keys[i] == digit_keys[k]) begin
                    d = k;
                end
            end
            if (keys[i] == input_pkg::key_backspace) begin
                if (count != 0) begin
                    value = value / 10;
                    count--;
                end
            end else if (d >= 0 && count < input_pkg::max_digits) begin
                value = value * 10 + word_t'(d);  // wraps at word size
                count++;
            end
        end
        return value;
    endfunction

    task automatic check_data(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "data mismatch in %s", name);
        end
    endtask

    task automatic check_state(input string name, input input_pkg::input_state_t expected,
                               input input_pkg::input_state_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %s actual %s", name, expected.name(), actual.name());
            $display("Simulation failed");
            $fatal(1, "state mismatch in %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "flag mismatch in %s", name);
        end
    endtask

    task automatic check_seg(input string name, input logic [6:0] expected,
                             input logic [6:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "segment mismatch in %s", name);
        end
    endtask

    task automatic check_cols(input string name, input logic [3:0] expected,
                              input logic [3:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "column drive mismatch in %s", name);
        end
    endtask

    // memory drops its request on the cycle that enter or pause ends the entry
    task automatic run_cycles(input int n);
        logic ending;
        repeat (n) begin
            @(negedge clk);
            ending = (DUT.key_coord == input_pkg::key_enter) ||
                     (DUT.key_coord == input_pkg::key_pause);
            @(posedge clk);
            if (ending) begin
                input_enable <= 1'b0;
            end
        end
    endtask

    task automatic press_key(input input_pkg::key_code_t key);
        @(posedge clk);
        held_key <= key;
        run_cycles(hold_cycles);
        held_key <= input_pkg::key_none;
        run_cycles(hold_cycles);
        @(negedge clk);  // outputs settled for checks
    endtask

    task automatic press_random_digits(input int n);
        input_pkg::key_code_t key;
        repeat (n) begin
            key = digit_keys[$urandom_range(9, 0)];
            entry.push_back(key);
            press_key(key);
        end
    endtask

    task automatic drive_enable(input logic level);
        @(posedge clk);
        input_enable <= level;
        run_cycles(2);
        @(negedge clk);
    endtask

    task automatic start_entry(input string name);
        entry.delete();
        drive_enable(1'b1);
        check_state(name, input_pkg::st_keypad, input_state);
        check_flag(name, 1'b0, input_complete);
        check_data(name, '0, input_data);
    endtask

    // walks the eight digit phases and checks segments and point
    task automatic check_display(input string name, input word_t value,
                                 input logic from_switches);
        for (int k = 0; k < 8; k++) begin
            while (digit_sel != ~(8'b1 << k)) begin
                @(negedge clk);
            end
            check_seg(name, seg_table[value[4*k +: 4]], seg);
            check_flag(name, !(from_switches && k == 7), dp);
        end
    endtask

    initial begin
        void'($urandom(32'h048dc622));
        held_key      = input_pkg::key_none;
        switch_map    = '0;
        uart_complete = 1'b0;
        input_enable  = 1'b0;
        @(posedge rst_n);
        @(negedge clk);
        check_state("reset state", input_pkg::st_block, input_state);
        check_flag("reset pause", 1'b0, cpu_pause);
        check_flag("reset switch", 1'b0, switch_enable);
        check_flag("reset complete", 1'b0, input_complete);
        check_cols("reset columns", 4'b1110, col_drive);

        start_entry("decimal start");
        press_random_digits($urandom_range(6, 3));
        press_key(input_pkg::key_enter);
        check_flag("decimal complete", 1'b1, input_complete);
        check_state("decimal state", input_pkg::st_block, input_state);
        check_data("decimal value", ref_keypad_value(entry), input_data);
        check_display("keypad display", ref_keypad_value(entry), 1'b0);

        start_entry("limit start");
        entry = {input_pkg::key_backspace, input_pkg::key_7, input_pkg::key_2, input_pkg::key_c,
                 input_pkg::key_backspace, input_pkg::key_9, input_pkg::key_1, input_pkg::key_4,
                 input_pkg::key_d, input_pkg::key_8, input_pkg::key_3, input_pkg::key_6,
                 input_pkg::key_5, input_pkg::key_2, input_pkg::key_9, input_pkg::key_0,
                 input_pkg::key_backspace, input_pkg::key_4, input_pkg::key_1};
        foreach (entry[i]) begin
            press_key(entry[i]);
        end
        press_key(input_pkg::key_enter);
        check_state("limit state", input_pkg::st_block, input_state);
        check_data("limit value", ref_keypad_value(entry), input_data);

        start_entry("switch start");
        press_random_digits(3);
        @(posedge clk);
        switch_map <= 16'($urandom);
        press_key(input_pkg::key_toggle);
        check_flag("switch enable", 1'b1, switch_enable);
        check_state("switch state", input_pkg::st_switch, input_state);
        check_data("switch value", word_t'(switch_map), input_data);
        check_display("switch display", word_t'(switch_map), 1'b1);
        press_key(input_pkg::key_toggle);
        check_flag("switch back", 1'b0, switch_enable);
        check_state("switch back state", input_pkg::st_keypad, input_state);
        check_data("switch back value", ref_keypad_value(entry), input_data);
        press_key(input_pkg::key_enter);
        check_state("switch end", input_pkg::st_block, input_state);

        start_entry("pause start");
        press_random_digits(2);
        press_key(input_pkg::key_pause);
        check_state("pause state", input_pkg::st_halt, input_state);
        check_flag("pause flag", 1'b1, cpu_pause);
        check_flag("pause complete", 1'b1, input_complete);
        press_key(input_pkg::key_pause);  // no upload yet, stays halted
        check_state("pause hold", input_pkg::st_halt, input_state);
        @(posedge clk);
        uart_complete <= 1'b1;
        press_key(input_pkg::key_pause);
        check_state("resume state", input_pkg::st_block, input_state);
        check_flag("resume flag", 1'b0, cpu_pause);
        @(posedge clk);
        uart_complete <= 1'b0;

        start_entry("hold start");
        press_random_digits(4);
        press_key(input_pkg::key_enter);
        drive_enable(1'b0);
        run_cycles(20);
        @(negedge clk);
        check_state("hold state", input_pkg::st_block, input_state);
        check_data("hold value", ref_keypad_value(entry), input_data);
        check_flag("hold complete", 1'b1, input_complete);
        drive_enable(1'b1);
        check_flag("new entry complete", 1'b0, input_complete);
        check_data("new entry value", '0, input_data);
        drive_enable(1'b0);
        check_state("fall back", input_pkg::st_block, input_state);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* sources.f */
input_pkg.sv
keypad_scanner.sv
input_unit.sv
hex_display.sv
input_subsystem.sv
tb_clock_gen.sv
tb_input_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the keypad input testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_input_subsystem \
    -f sources.f \
    -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit $status
fi

exit 0
